/* verilog/rs_pkg.sv */
`default_nettype none

package rs_pkg;

    localparam int data_w     = 32;
    localparam int preg_count = 64;
    localparam int preg_w     = 6;
    localparam int robid_w    = 6;
    localparam int opcode_w   = 4;

    // How a source operand is obtained
    typedef enum logic [1:0] {
        op_zero = 2'd0,
        op_imm  = 2'd1,
        op_reg  = 2'd2
    } optype_e;

    typedef enum logic {
        fu_exe = 1'b0,
        fu_mem = 1'b1
    } fu_class_e;

    // Register view of a source word
    typedef struct packed {
        logic [data_w-preg_w-1:0] unused;
        logic [preg_w-1:0]        tag;
    } rs_reg_view_t;

    // Source word, view picked by the optype of the same source
    typedef union packed {
        logic [data_w-1:0] imm;
        rs_reg_view_t      preg;
    } rs_operand_u;

endpackage

`default_nettype wire

/* verilog/rs_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_alloc
    import rs_pkg::*;
#(
    parameter int num_ents = 8
) (
    input  logic                  nuke,
    input  logic                  disp_valid,
    input  optype_e               disp_src1_type,
    input  rs_operand_u           disp_src1,
    input  optype_e               disp_src2_type,
    input  rs_operand_u           disp_src2,
    input  logic [preg_w-1:0]     disp_pdst,
    input  logic [num_ents-1:0]   ent_valid,
    input  logic [preg_count-1:0] preg_ready,
    input  logic                  wb_en,
    input  logic [preg_w-1:0]     wb_tag,
    output logic                  stall,
    output logic [num_ents-1:0]   alloc,
    output logic                  alloc_src1_rdy,
    output logic                  alloc_src2_rdy,
    output logic                  pdst_clear_en
);

logic                take;
logic [num_ents-1:0] free;
logic [num_ents-1:0] first_free;
logic [preg_w-1:0]   src1_tag;
logic [preg_w-1:0]   src2_tag;

assign stall = &ent_valid;

// A dispatch that meets a flush is younger than it and is dropped
assign take = disp_valid & ~stall & ~nuke;

// Lowest free entry
assign free       = ~ent_valid;
assign first_free = free & (~free + 1'b1);
assign alloc      = take ? first_free : '0;

// New destination is busy until its writeback
assign pdst_clear_en = take;

assign src1_tag = disp_src1.preg.tag;
assign src2_tag = disp_src2.preg.tag;

// Ready from the scoreboard or a writeback in this same cycle
assign alloc_src1_rdy = (disp_src1_type != op_reg) || preg_ready[src1_tag] ||
                        (wb_en && wb_tag == src1_tag);
assign alloc_src2_rdy = (disp_src2_type != op_reg) || preg_ready[src2_tag] ||
                        (wb_en && wb_tag == src2_tag);

endmodule

`default_nettype wire

/* verilog/rs_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_entry
    import rs_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                nuke,
    input  logic                alloc,
    input  logic                alloc_src1_rdy,
    input  logic                alloc_src2_rdy,
    input  fu_class_e           disp_class,
    input  logic [opcode_w-1:0] disp_opcode,
    input  logic [robid_w-1:0]  disp_robid,
    input  logic [preg_w-1:0]   disp_pdst,
    input  optype_e             disp_src1_type,
    input  rs_operand_u         disp_src1,
    input  optype_e             disp_src2_type,
    input  rs_operand_u         disp_src2,
    input  logic                wb_en,
    input  logic [preg_w-1:0]   wb_tag,
    input  logic                gnt,
    output logic                valid,
    output logic                req,
    output fu_class_e           ent_class,
    output logic [opcode_w-1:0] ent_opcode,
    output logic [robid_w-1:0]  ent_robid,
    output logic [preg_w-1:0]   ent_pdst,
    output optype_e             ent_src1_type,
    output rs_operand_u         ent_src1,
    output optype_e             ent_src2_type,
    output rs_operand_u         ent_src2
);

logic src1_rdy;
logic src2_rdy;
logic wake1;
logic wake2;

// Writeback to a waiting register source
assign wake1 = wb_en && ent_src1_type == op_reg && ent_src1.preg.tag == wb_tag;
assign wake2 = wb_en && ent_src2_type == op_reg && ent_src2.preg.tag == wb_tag;

assign req = valid & src1_rdy & src2_rdy;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        valid <= 1'b0;
    end else if (nuke) begin
        valid <= 1'b0;
    end else if (alloc) begin
        valid <= 1'b1;
    end else if (gnt) begin
        valid <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        src1_rdy <= 1'b0;
        src2_rdy <= 1'b0;
    end else if (alloc) begin
        src1_rdy <= alloc_src1_rdy;
        src2_rdy <= alloc_src2_rdy;
    end else begin
        if (wake1) begin
            src1_rdy <= 1'b1;
        end
        if (wake2) begin
            src2_rdy <= 1'b1;
        end
    end
end

// Micro-op fields, held until the entry is reused
always_ff @(posedge clk) begin
    if (alloc) begin
        ent_class     <= disp_class;
        ent_opcode    <= disp_opcode;
        ent_robid     <= disp_robid;
        ent_pdst      <= disp_pdst;
        ent_src1_type <= disp_src1_type;
        ent_src1      <= disp_src1;
        ent_src2_type <= disp_src2_type;
        ent_src2      <= disp_src2;
    end
end

endmodule

`default_nettype wire

/* verilog/rs_age_select.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_age_select #(
    parameter int num_ents = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [num_ents-1:0] alloc,
    input  logic [num_ents-1:0] req,
    output logic [num_ents-1:0] sel
);

// older[i][j] set means entry j was allocated before entry i
logic [num_ents-1:0] older [num_ents];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < num_ents; i++) begin
            older[i] <= '0;
        end
    end else begin
        for (int i = 0; i < num_ents; i++) begin
            for (int j = 0; j < num_ents; j++) begin
                if (alloc[i]) begin
                    // New entry is younger than everything present
                    older[i][j] <= (i != j);
                end else if (alloc[j]) begin
                    older[i][j] <= 1'b0;
                end
            end
        end
    end
end

// Oldest requester has no older requester
always_comb begin
    for (int i = 0; i < num_ents; i++) begin
        sel[i] = req[i] & ~|(older[i] & req);
    end
end

endmodule

`default_nettype wire

/* verilog/prf.sv */
`timescale 1ns/1ps
`default_nettype none

module prf
    import rs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wb_en,
    input  logic [preg_w-1:0]     wb_tag,
    input  logic [data_w-1:0]     wb_data,
    input  logic [preg_w-1:0]     rd_addr1,
    input  logic [preg_w-1:0]     rd_addr2,
    input  logic                  pdst_clear_en,
    input  logic [preg_w-1:0]     pdst_clear_tag,
    output logic [data_w-1:0]     rd_data1,
    output logic [data_w-1:0]     rd_data2,
    output logic [preg_count-1:0] preg_ready
);

logic [data_w-1:0] regs [preg_count];

// Registers start at zero and ready
always_ff @(posedge clk) begin
    if (!rst_n) begin
        for (int i = 0; i < preg_count; i++) begin
            regs[i] <= '0;
        end
    end else if (wb_en) begin
        regs[wb_tag] <= wb_data;
    end
end

// Scoreboard, writeback wins over a clear of the same tag
always_ff @(posedge clk) begin
    if (!rst_n) begin
        preg_ready <= '1;
    end else begin
        if (pdst_clear_en) begin
            preg_ready[pdst_clear_tag] <= 1'b0;
        end
        if (wb_en) begin
            preg_ready[wb_tag] <= 1'b1;
        end
    end
end

// Registered reads with write bypass
always_ff @(posedge clk) begin
    rd_data1 <= (wb_en && wb_tag == rd_addr1) ? wb_data : regs[rd_addr1];
    rd_data2 <= (wb_en && wb_tag == rd_addr2) ? wb_data : regs[rd_addr2];
end

endmodule

`default_nettype wire

/* verilog/rs_issue_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_issue_stage
    import rs_pkg::*;
#(
    parameter int num_ents = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                nuke,
    input  logic [num_ents-1:0] sel,
    input  fu_class_e           ent_class     [num_ents],
    input  logic [opcode_w-1:0] ent_opcode    [num_ents],
    input  logic [robid_w-1:0]  ent_robid     [num_ents],
    input  logic [preg_w-1:0]   ent_pdst      [num_ents],
    input  optype_e             ent_src1_type [num_ents],
    input  rs_operand_u         ent_src1      [num_ents],
    input  optype_e             ent_src2_type [num_ents],
    input  rs_operand_u         ent_src2      [num_ents],
    input  logic [data_w-1:0]   rd_data1,
    input  logic [data_w-1:0]   rd_data2,
    output logic [num_ents-1:0] gnt,
    output logic [preg_w-1:0]   rd_addr1,
    output logic [preg_w-1:0]   rd_addr2,
    output logic                ex_iss,
    output logic                mm_iss,
    output logic [opcode_w-1:0] iss_opcode,
    output logic [robid_w-1:0]  iss_robid,
    output logic [preg_w-1:0]   iss_pdst,
    output logic [data_w-1:0]   iss_src1_val,
    output logic [data_w-1:0]   iss_src2_val
);

logic                sel_mem;
logic [opcode_w-1:0] sel_opcode;
logic [robid_w-1:0]  sel_robid;
logic [preg_w-1:0]   sel_pdst;
logic [1:0]          sel_src1_type;
logic [1:0]          sel_src2_type;
rs_operand_u         sel_src1;
rs_operand_u         sel_src2;

logic                iss_v_q;
fu_class_e           iss_class_q;
optype_e             iss_src1_type_q;
optype_e             iss_src2_type_q;
rs_operand_u         iss_src1_q;
rs_operand_u         iss_src2_q;

function automatic logic [data_w-1:0] opsel(
    input optype_e           optype,
    input rs_operand_u       word,
    input logic [data_w-1:0] prf_data
);
    case (optype)
        op_imm:  return word.imm;
        op_reg:  return prf_data;
        default: return '0;
    endcase
endfunction

// AND-OR mux of the one-hot selected entry
always_comb begin
    sel_mem       = 1'b0;
    sel_opcode    = '0;
    sel_robid     = '0;
    sel_pdst      = '0;
    sel_src1_type = '0;
    sel_src2_type = '0;
    sel_src1      = '0;
    sel_src2      = '0;
    for (int i = 0; i < num_ents; i++) begin
        sel_mem       = sel_mem | (sel[i] & (ent_class[i] == fu_mem));
        sel_opcode    = sel_opcode | (ent_opcode[i] & {opcode_w{sel[i]}});
        sel_robid     = sel_robid | (ent_robid[i] & {robid_w{sel[i]}});
        sel_pdst      = sel_pdst | (ent_pdst[i] & {preg_w{sel[i]}});
        sel_src1_type = sel_src1_type | (ent_src1_type[i] & {2{sel[i]}});
        sel_src2_type = sel_src2_type | (ent_src2_type[i] & {2{sel[i]}});
        sel_src1      = sel_src1 | (ent_src1[i] & {data_w{sel[i]}});
        sel_src2      = sel_src2 | (ent_src2[i] & {data_w{sel[i]}});
    end
end

// No grant while flushing
assign gnt = nuke ? '0 : sel;

assign rd_addr1 = sel_src1.preg.tag;
assign rd_addr2 = sel_src2.preg.tag;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        iss_v_q <= 1'b0;
    end else begin
        iss_v_q <= |gnt;
    end
end

always_ff @(posedge clk) begin
    iss_class_q     <= sel_mem ? fu_mem : fu_exe;
    iss_opcode      <= sel_opcode;
    iss_robid       <= sel_robid;
    iss_pdst        <= sel_pdst;
    iss_src1_type_q <= optype_e'(sel_src1_type);
    iss_src2_type_q <= optype_e'(sel_src2_type);
    iss_src1_q      <= sel_src1;
    iss_src2_q      <= sel_src2;
end

// Operands resolved once the register data arrives
assign iss_src1_val = opsel(iss_src1_type_q, iss_src1_q, rd_data1);
assign iss_src2_val = opsel(iss_src2_type_q, iss_src2_q, rd_data2);

// A flush also kills the staged issue
assign ex_iss = iss_v_q & (iss_class_q == fu_exe) & ~nuke;
assign mm_iss = iss_v_q & (iss_class_q == fu_mem) & ~nuke;

endmodule

`default_nettype wire

/* verilog/rs_sched.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_sched
    import rs_pkg::*;
#(
    parameter int num_ents = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                nuke,
    input  logic                disp_valid,
    input  fu_class_e           disp_class,
    input  logic [opcode_w-1:0] disp_opcode,
    input  logic [robid_w-1:0]  disp_robid,
    input  logic [preg_w-1:0]   disp_pdst,
    input  optype_e             disp_src1_type,
    input  rs_operand_u         disp_src1,
    input  optype_e             disp_src2_type,
    input  rs_operand_u         disp_src2,
    input  logic                wb_en,
    input  logic [preg_w-1:0]   wb_tag,
    input  logic [data_w-1:0]   wb_data,
    output logic                stall,
    output logic                ex_iss,
    output logic                mm_iss,
    output logic [opcode_w-1:0] iss_opcode,
    output logic [robid_w-1:0]  iss_robid,
    output logic [preg_w-1:0]   iss_pdst,
    output logic [data_w-1:0]   iss_src1_val,
    output logic [data_w-1:0]   iss_src2_val
);

logic [num_ents-1:0]   alloc;
logic                  alloc_src1_rdy;
logic                  alloc_src2_rdy;
logic                  pdst_clear_en;
logic [num_ents-1:0]   ent_valid;
logic [num_ents-1:0]   ent_req;
logic [num_ents-1:0]   sel;
logic [num_ents-1:0]   gnt;
logic [preg_count-1:0] preg_ready;
logic [preg_w-1:0]     rd_addr1;
logic [preg_w-1:0]     rd_addr2;
logic [data_w-1:0]     rd_data1;
logic [data_w-1:0]     rd_data2;

fu_class_e             ent_class     [num_ents];
logic [opcode_w-1:0]   ent_opcode    [num_ents];
logic [robid_w-1:0]    ent_robid     [num_ents];
logic [preg_w-1:0]     ent_pdst      [num_ents];
optype_e               ent_src1_type [num_ents];
rs_operand_u           ent_src1      [num_ents];
optype_e               ent_src2_type [num_ents];
rs_operand_u           ent_src2      [num_ents];

rs_alloc #(
    .num_ents(num_ents)
) rs_alloc_i (
    .nuke,
    .disp_valid,
    .disp_src1_type,
    .disp_src1,
    .disp_src2_type,
    .disp_src2,
    .disp_pdst,
    .ent_valid,
    .preg_ready,
    .wb_en,
    .wb_tag,
    .stall,
    .alloc,
    .alloc_src1_rdy,
    .alloc_src2_rdy,
    .pdst_clear_en
);

for (genvar i = 0; i < num_ents; i++) begin : g_entries
    rs_entry rs_entry_i (
        .clk,
        .rst_n,
        .nuke,
        .alloc          (alloc[i]),
        .alloc_src1_rdy,
        .alloc_src2_rdy,
        .disp_class,
        .disp_opcode,
        .disp_robid,
        .disp_pdst,
        .disp_src1_type,
        .disp_src1,
        .disp_src2_type,
        .disp_src2,
        .wb_en,
        .wb_tag,
        .gnt            (gnt[i]),
        .valid          (ent_valid[i]),
        .req            (ent_req[i]),
        .ent_class      (ent_class[i]),
        .ent_opcode     (ent_opcode[i]),
        .ent_robid      (ent_robid[i]),
        .ent_pdst       (ent_pdst[i]),
        .ent_src1_type  (ent_src1_type[i]),
        .ent_src1       (ent_src1[i]),
        .ent_src2_type  (ent_src2_type[i]),
        .ent_src2       (ent_src2[i])
    );
end

rs_age_select #(
    .num_ents(num_ents)
) rs_age_select_i (
    .clk,
    .rst_n,
    .alloc,
    .req   (ent_req),
    .sel
);

prf prf_i (
    .clk,
    .rst_n,
    .wb_en,
    .wb_tag,
    .wb_data,
    .rd_addr1,
    .rd_addr2,
    .pdst_clear_en,
    .pdst_clear_tag (disp_pdst),
    .rd_data1,
    .rd_data2,
    .preg_ready
);

rs_issue_stage #(
    .num_ents(num_ents)
) rs_issue_stage_i (
    .clk,
    .rst_n,
    .nuke,
    .sel,
    .ent_class,
    .ent_opcode,
    .ent_robid,
    .ent_pdst,
    .ent_src1_type,
    .ent_src1,
    .ent_src2_type,
    .ent_src2,
    .rd_data1,
    .rd_data2,
    .gnt,
    .rd_addr1,
    .rd_addr2,
    .ex_iss,
    .mm_iss,
    .iss_opcode,
    .iss_robid,
    .iss_pdst,
    .iss_src1_val,
    .iss_src2_val
);

endmodule

`default_nettype wire

/* bench/rs_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_checker
    import rs_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ex_iss,
    input  logic                mm_iss,
    input  logic [opcode_w-1:0] iss_opcode,
    input  logic [robid_w-1:0]  iss_robid,
    input  logic [preg_w-1:0]   iss_pdst,
    input  logic [data_w-1:0]   iss_src1_val,
    input  logic [data_w-1:0]   iss_src2_val,
    input  logic                exp_push,
    input  fu_class_e           exp_class,
    input  logic [opcode_w-1:0] exp_opcode,
    input  logic [robid_w-1:0]  exp_robid,
    input  logic [preg_w-1:0]   exp_pdst,
    input  logic [data_w-1:0]   exp_v1,
    input  logic [data_w-1:0]   exp_v2,
    output int                  pending,
    output int                  pass_cnt,
    output int                  err_cnt
);

typedef struct packed {
    fu_class_e           cls;
    logic [opcode_w-1:0] opcode;
    logic [robid_w-1:0]  robid;
    logic [preg_w-1:0]   pdst;
    logic [data_w-1:0]   v1;
    logic [data_w-1:0]   v2;
} issue_t;

issue_t exp_q [$];
issue_t e;
issue_t got;

function automatic string issue_text(input issue_t i);
    return $sformatf("robid %0d class %0d op %0d pdst %0d src %h %h",
                     i.robid, i.cls, i.opcode, i.pdst, i.v1, i.v2);
endfunction

// Sampled mid-cycle, away from the clock edge
always @(negedge clk) begin
    if (!rst_n) begin
        pass_cnt = 0;
        err_cnt  = 0;
        exp_q.delete();
    end else begin
        if (exp_push) begin
            e.cls    = exp_class;
            e.opcode = exp_opcode;
            e.robid  = exp_robid;
            e.pdst   = exp_pdst;
            e.v1     = exp_v1;
            e.v2     = exp_v2;
            exp_q.push_back(e);
        end
        if (ex_iss && mm_iss) begin
            err_cnt++;
            $display("Both issue ports were high at %0t", $time);
        end else if (ex_iss || mm_iss) begin
            got.cls    = mm_iss ? fu_mem : fu_exe;
            got.opcode = iss_opcode;
            got.robid  = iss_robid;
            got.pdst   = iss_pdst;
            got.v1     = iss_src1_val;
            got.v2     = iss_src2_val;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Unexpected issue of robid %0d at %0t, nothing was pending",
                         iss_robid, $time);
            end else begin
                e = exp_q.pop_front();
                if (got != e) begin
                    err_cnt++;
                    $display("[ERROR] %0t: issue mismatch, got %s, expected %s",
                             $time, issue_text(got), issue_text(e));
                end else begin
                    pass_cnt++;
                end
            end
        end
    end
    pending = exp_q.size();
end

endmodule

`default_nettype wire

/* bench/rs_sched_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rs_sched_tb
    import rs_pkg::*;
;

localparam logic [1:0] act_idle = 2'd0;
localparam logic [1:0] act_disp = 2'd1;
localparam logic [1:0] act_wb   = 2'd2;
localparam logic [1:0] act_nuke = 2'd3;

typedef struct packed {
    logic [3:0]          test;
    logic [1:0]          act;
    fu_class_e           cls;
    logic [robid_w-1:0]  robid;
    logic [preg_w-1:0]   pdst;
    optype_e             t1;
    logic [data_w-1:0]   s1;
    optype_e             t2;
    logic [data_w-1:0]   s2;
    logic [preg_w-1:0]   wb_tag;
    logic [data_w-1:0]   wb_data;
    logic                exp_iss;
    fu_class_e           exp_cls;
    logic [opcode_w-1:0] exp_opcode;
    logic [robid_w-1:0]  exp_robid;
    logic [preg_w-1:0]   exp_pdst;
    logic [data_w-1:0]   exp_v1;
    logic [data_w-1:0]   exp_v2;
    logic                exp_stall;
} row_t;

logic clk = 1'b0;
logic rst_n;
logic nuke;
logic disp_valid;
fu_class_e disp_class;
logic [opcode_w-1:0] disp_opcode;
logic [robid_w-1:0] disp_robid;
logic [preg_w-1:0] disp_pdst;
optype_e disp_src1_type;
rs_operand_u disp_src1;
optype_e disp_src2_type;
rs_operand_u disp_src2;
logic wb_en;
logic [preg_w-1:0] wb_tag;
logic [data_w-1:0] wb_data;
logic stall;
logic ex_iss;
logic mm_iss;
logic [opcode_w-1:0] iss_opcode;
logic [robid_w-1:0] iss_robid;
logic [preg_w-1:0] iss_pdst;
logic [data_w-1:0] iss_src1_val;
logic [data_w-1:0] iss_src2_val;

logic exp_push;
fu_class_e exp_class;
logic [opcode_w-1:0] exp_opcode;
logic [robid_w-1:0] exp_robid;
logic [preg_w-1:0] exp_pdst;
logic [data_w-1:0] exp_v1;
logic [data_w-1:0] exp_v2;
int pending;
int pass_cnt;
int err_cnt;

row_t tbl [$];
int seed;
int tb_errs = 0;
int cycle_cnt = 0;
int limit_cycles = 0;

always #10 clk = ~clk;

rs_sched #(
    .num_ents(8)
) rs_sched_i (
    .clk, .rst_n, .nuke,
    .disp_valid, .disp_class, .disp_opcode, .disp_robid, .disp_pdst,
    .disp_src1_type, .disp_src1, .disp_src2_type, .disp_src2,
    .wb_en, .wb_tag, .wb_data,
    .stall, .ex_iss, .mm_iss, .iss_opcode, .iss_robid, .iss_pdst,
    .iss_src1_val, .iss_src2_val
);

rs_checker rs_checker_i (
    .clk, .rst_n, .ex_iss, .mm_iss,
    .iss_opcode, .iss_robid, .iss_pdst, .iss_src1_val, .iss_src2_val,
    .exp_push, .exp_class, .exp_opcode, .exp_robid, .exp_pdst, .exp_v1, .exp_v2,
    .pending, .pass_cnt, .err_cnt
);

always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (limit_cycles > 0 && cycle_cnt >= limit_cycles) begin
        $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end
end

function automatic logic [data_w-1:0] tag_word(input int tag);
    return {{(data_w-preg_w){1'b0}}, tag[preg_w-1:0]};
endfunction

// The opcode of each micro-op is the low bits of its robid
task automatic add_disp(input int test, input fu_class_e cls, input int robid, input int pdst,
                        input optype_e t1, input logic [data_w-1:0] s1,
                        input optype_e t2, input logic [data_w-1:0] s2,
                        input logic issues, input logic [data_w-1:0] v1,
                        input logic [data_w-1:0] v2);
    row_t r;
    r = '0;
    r.test = test[3:0];
    r.act = act_disp;
    r.cls = cls;
    r.robid = robid[robid_w-1:0];
    r.pdst = pdst[preg_w-1:0];
    r.t1 = t1;
    r.s1 = s1;
    r.t2 = t2;
    r.s2 = s2;
    r.exp_iss = issues;
    r.exp_cls = cls;
    r.exp_opcode = robid[opcode_w-1:0];
    r.exp_robid = robid[robid_w-1:0];
    r.exp_pdst = pdst[preg_w-1:0];
    r.exp_v1 = v1;
    r.exp_v2 = v2;
    tbl.push_back(r);
endtask

// Writeback row, optionally releasing an older waiting micro-op
task automatic add_wb(input int test, input int tag, input logic [data_w-1:0] data,
                      input logic issues, input fu_class_e cls, input int robid,
                      input int pdst, input logic [data_w-1:0] v1,
                      input logic [data_w-1:0] v2);
    row_t r;
    r = '0;
    r.test = test[3:0];
    r.act = act_wb;
    r.wb_tag = tag[preg_w-1:0];
    r.wb_data = data;
    r.exp_iss = issues;
    r.exp_cls = cls;
    r.exp_opcode = robid[opcode_w-1:0];
    r.exp_robid = robid[robid_w-1:0];
    r.exp_pdst = pdst[preg_w-1:0];
    r.exp_v1 = v1;
    r.exp_v2 = v2;
    tbl.push_back(r);
endtask

task automatic add_ctrl(input int test, input logic [1:0] act);
    row_t r;
    r = '0;
    r.test = test[3:0];
    r.act = act;
    tbl.push_back(r);
endtask

// Last dispatch meets a full station and is freed by this writeback
task automatic mark_stall(input int tag, input logic [data_w-1:0] data);
    row_t r;
    r = tbl[tbl.size()-1];
    r.exp_stall = 1'b1;
    r.wb_tag = tag[preg_w-1:0];
    r.wb_data = data;
    tbl[tbl.size()-1] = r;
endtask

task automatic build_table();
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] c;
    logic [data_w-1:0] d;
    a = $random(seed);
    b = $random(seed);
    c = $random(seed);
    d = $random(seed);
    // Immediate and zero operands
    add_disp(1, fu_exe, 1, 40, op_imm, a, op_zero, b, 1'b1, a, '0);
    add_disp(1, fu_mem, 2, 41, op_zero, c, op_imm, d, 1'b1, '0, d);
    add_disp(1, fu_exe, 3, 42, op_imm, b, op_imm, c, 1'b1, b, c);
    // Registers written earlier
    add_wb(2, 5, 32'h1111_0005, 1'b0, fu_exe, 0, 0, '0, '0);
    add_wb(2, 6, 32'h2222_0006, 1'b0, fu_exe, 0, 0, '0, '0);
    add_disp(2, fu_exe, 4, 43, op_reg, tag_word(5), op_reg, tag_word(6), 1'b1,
             32'h1111_0005, 32'h2222_0006);
    add_disp(2, fu_mem, 5, 44, op_reg, tag_word(6), op_imm, a, 1'b1, 32'h2222_0006, a);
    // Wait on a producer tag, younger ready op goes first
    add_disp(3, fu_exe, 6, 10, op_imm, c, op_zero, a, 1'b1, c, '0);
    add_disp(3, fu_exe, 7, 45, op_reg, tag_word(10), op_imm, d, 1'b0, '0, '0);
    add_disp(3, fu_mem, 8, 46, op_imm, a, op_zero, b, 1'b1, a, '0);
    add_wb(3, 10, 32'ha5a5_0010, 1'b1, fu_exe, 7, 45, 32'ha5a5_0010, d);
    // Back to back ready ops
    for (int k = 0; k < 3; k++) begin
        a = $random(seed);
        b = $random(seed);
        add_disp(4, (k == 1) ? fu_mem : fu_exe, 9 + k, 47 + k, op_imm, a, op_imm, b, 1'b1, a, b);
    end
    // Fill every entry behind tag 20
    a = $random(seed);
    add_disp(5, fu_exe, 12, 20, op_imm, a, op_zero, a, 1'b1, a, '0);
    for (int k = 0; k < 8; k++) begin
        b = $random(seed);
        add_disp(5, (k % 2 == 1) ? fu_mem : fu_exe, 13 + k, 51 + k, op_reg, tag_word(20),
                 op_imm, b, 1'b1, 32'h5eed_0020, b);
    end
    c = $random(seed);
    d = $random(seed);
    add_disp(5, fu_mem, 21, 50, op_imm, c, op_imm, d, 1'b1, c, d);
    mark_stall(20, 32'h5eed_0020);
    // Flush of a waiting op and one in flight
    a = $random(seed);
    b = $random(seed);
    add_disp(6, fu_exe, 22, 30, op_imm, a, op_imm, b, 1'b0, '0, '0);
    add_disp(6, fu_mem, 23, 60, op_reg, tag_word(30), op_zero, a, 1'b0, '0, '0);
    add_ctrl(6, act_nuke);
    add_ctrl(6, act_idle);
    // Flush of a full station, tag 40 is never written
    for (int k = 0; k < 8; k++) begin
        add_disp(6, fu_exe, 25 + k, 32 + k, op_reg, tag_word(40), op_imm, a,
                 1'b0, '0, '0);
    end
    add_ctrl(6, act_nuke);
    add_disp(6, fu_mem, 24, 61, op_imm, b, op_imm, a, 1'b1, b, a);
endtask

task automatic idle_inputs();
    nuke = 1'b0;
    disp_valid = 1'b0;
    disp_class = fu_exe;
    disp_opcode = '0;
    disp_robid = '0;
    disp_pdst = '0;
    disp_src1_type = op_zero;
    disp_src1 = '0;
    disp_src2_type = op_zero;
    disp_src2 = '0;
    wb_en = 1'b0;
    wb_tag = '0;
    wb_data = '0;
endtask

// Starts and ends 2 ns after a rising edge
task automatic run_row(input row_t r);
    int retries;
    retries = 0;
    case (r.act)
        act_disp: begin
            disp_valid = 1'b1;
            disp_class = r.cls;
            disp_opcode = r.robid[opcode_w-1:0];
            disp_robid = r.robid;
            disp_pdst = r.pdst;
            disp_src1_type = r.t1;
            disp_src1 = r.s1;
            disp_src2_type = r.t2;
            disp_src2 = r.s2;
            if (r.exp_stall) begin
                #1;
                if (!stall) begin
                    tb_errs++;
                    $display("Stall was not raised for the dispatch of robid %0d", r.robid);
                end
                @(posedge clk);
                #2;
                retries = 1;
                wb_en = 1'b1;
                wb_tag = r.wb_tag;
                wb_data = r.wb_data;
                @(posedge clk);
                #2;
                wb_en = 1'b0;
            end
            #1;
            while (stall) begin
                if (r.exp_stall) begin
                    retries++;
                end
                @(posedge clk);
                #3;
            end
        end
        act_wb: begin
            wb_en = 1'b1;
            wb_tag = r.wb_tag;
            wb_data = r.wb_data;
        end
        act_nuke: nuke = 1'b1;
        default: ;
    endcase
    if (r.exp_iss) begin
        exp_push = 1'b1;
        exp_class = r.exp_cls;
        exp_opcode = r.exp_opcode;
        exp_robid = r.exp_robid;
        exp_pdst = r.exp_pdst;
        exp_v1 = r.exp_v1;
        exp_v2 = r.exp_v2;
    end
    @(posedge clk);
    #2;
    exp_push = 1'b0;
    idle_inputs();
    if (r.exp_stall) begin
        $display("Dispatch of robid %0d waited %0d stalled cycles", r.robid, retries);
    end
    if (r.act == act_nuke && stall) begin
        tb_errs++;
        $display("Stall was still high after the flush");
    end
endtask

task automatic finish_test(input int test, input int errs_before);
    int waited;
    waited = 0;
    while (pending != 0 && waited < 40) begin
        @(posedge clk);
        #2;
        waited++;
    end
    if (pending != 0) begin
        tb_errs++;
        $display("Test %0d: %0d expected issues never appeared", test, pending);
    end
    repeat (4) @(posedge clk);
    #2;
    $display("Test %0d finished with %0d errors", test, tb_errs + err_cnt - errs_before);
endtask

initial begin
    int errs_before;
    int total;
    seed = 32'h477e1442;
    rst_n = 1'b0;
    exp_push = 1'b0;
    exp_class = fu_exe;
    exp_opcode = '0;
    exp_robid = '0;
    exp_pdst = '0;
    exp_v1 = '0;
    exp_v2 = '0;
    idle_inputs();
    build_table();
    limit_cycles = tbl.size() * 20 + 200;
    repeat (4) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    errs_before = 0;
    for (int i = 0; i < tbl.size(); i++) begin
        run_row(tbl[i]);
        if (i == tbl.size() - 1 || tbl[i+1].test != tbl[i].test) begin
            finish_test(tbl[i].test, errs_before);
            errs_before = tb_errs + err_cnt;
        end
    end
    total = tb_errs + err_cnt;
    $display("Checks passed %0d, errors %0d", pass_cnt, total);
    if (total == 0) begin
        $display("TEST RESULT: PASS");
    end else begin
        $display("TEST RESULT: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

/* rs_sched.f */
verilog/rs_pkg.sv
verilog/rs_alloc.sv
verilog/rs_entry.sv
verilog/rs_age_select.sv
verilog/prf.sv
verilog/rs_issue_stage.sv
verilog/rs_sched.sv
bench/rs_checker.sv
bench/rs_sched_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the reservation station testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module rs_sched_tb -f rs_sched.f -o rs_sched_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rs_sched_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$log"; then
    exit 0
fi

echo "Simulation did not report a pass"
exit 1
